//--- Makefile
# Verilator build and run for the eye scan testbench
# Any variable below can be overridden, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tbEyeScan
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= All tests passed!

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail is taken from the simulation output
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qF "$(PASS_TEXT)"; then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

//--- drpMaster.sv
// ----------------------------------------
// DRP master, one request pulse in, one transaction out
// opDone pulses the cycle after drpRdy with the read data
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module drpMaster
    import eyeScanPkg::*;
(
    input  wire logic    CLK,
    input  wire logic    rstN,
    input  wire logic    reqStrobe,
    input  wire logic    reqWrite,
    input  wire drpAddrT reqAddr,
    input  wire drpDataT reqData,
    input  wire drpDataT drpDo,
    input  wire logic    drpRdy,
    output drpAddrT      drpAddr,
    output drpDataT      drpDi,
    output logic         drpEn,
    output logic         drpWe,
    output logic         opDone,
    output drpDataT      rdData
);

    logic busy; // Waiting for drpRdy

    // Control strobes
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            drpEn  <= 1'b0;
            drpWe  <= 1'b0;
            busy   <= 1'b0;
            opDone <= 1'b0;
        end else begin
            drpEn  <= reqStrobe;            // Single enable cycle
            drpWe  <= reqStrobe && reqWrite;
            opDone <= busy && drpRdy;
            if (reqStrobe) begin
                busy <= 1'b1;
            end else if (drpRdy) begin
                busy <= 1'b0;
            end
        end
    end

    // Address and data are only driven during the enable cycle
    always_ff @(posedge CLK) begin
        drpAddr <= reqStrobe ? reqAddr : '0;
        drpDi   <= (reqStrobe && reqWrite) ? reqData : '0;
        if (busy && drpRdy) begin
            rdData <= drpDo;
        end
    end

endmodule

`default_nettype wire

//--- eyeScan.sv
// ----------------------------------------
// Eye scan controller top level
// Sequencer drives the DRP master, results go to the pixel store
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module eyeScan
    import eyeScanPkg::*;
(
    input  wire logic      CLK,
    input  wire logic      rstN,
    input  wire logic      runScan,   // Rising edge starts, falling edge aborts
    input  wire prescaleT  prescale,
    output logic           scanComplete,
    output drpAddrT        drpAddr,
    output drpDataT        drpDi,
    output logic           drpEn,
    output logic           drpWe,
    input  wire drpDataT   drpDo,
    input  wire logic      drpRdy,
    input  wire pixelAddrT rdAddr,
    output drpDataT        rdVert,
    output drpDataT        rdHorz,
    output countT          rdSamples,
    output countT          rdErrors
);

    // Sequencer to DRP master
    logic    reqStrobe;
    logic    reqWrite;
    drpAddrT reqAddr;
    drpDataT reqData;
    logic    opDone;
    drpDataT rdData;

    // Sequencer to pixel store
    logic      pixWe;
    pixelAddrT pixAddr;
    drpDataT   pixVert;
    drpDataT   pixHorz;
    countT     pixSamples;
    countT     pixErrors;

    sweepSequencer u_sweepSequencer (
        .CLK, .rstN, .runScan, .prescale, .opDone, .rdData,
        .reqStrobe, .reqWrite, .reqAddr, .reqData,
        .pixWe, .pixAddr, .pixVert, .pixHorz, .pixSamples, .pixErrors,
        .scanComplete
    );

    drpMaster u_drpMaster (
        .CLK, .rstN, .reqStrobe, .reqWrite, .reqAddr, .reqData,
        .drpDo, .drpRdy, .drpAddr, .drpDi, .drpEn, .drpWe, .opDone, .rdData
    );

    pixelStore u_pixelStore (
        .CLK, .pixWe, .pixAddr, .pixVert, .pixHorz, .pixSamples, .pixErrors,
        .rdAddr, .rdVert, .rdHorz, .rdSamples, .rdErrors
    );

endmodule

`default_nettype wire

//--- eyeScanPkg.sv
// ----------------------------------------
// Shared types for the eye scan controller
// Imported by the sequencer, DRP master, store and top
// ----------------------------------------
`default_nettype none

package eyeScanPkg;

    // DRP bus
    typedef logic [8:0]  drpAddrT;
    typedef logic [15:0] drpDataT;

    typedef logic [15:0] countT;     // Sample or error count
    typedef logic [4:0]  prescaleT;  // Vertical word bits 15..11
    typedef logic [4:0]  pixelAddrT; // Up to 32 pixels

    // Grid counters
    typedef logic [3:0]  colT;
    typedef logic [2:0]  rowT;

    // Sequencer steps, one per DRP access plus store
    typedef enum logic [3:0] {
        seqIdle,
        seqVert,
        seqHorz,
        seqRun,
        seqPollRun,
        seqPollDone,
        seqStop,
        seqSamples,
        seqErrors,
        seqStore
    } seqStateT;

endpackage

`default_nettype wire

//--- eyeScan_defines.svh
// ----------------------------------------
// Eye scan grid, DRP register map and command words
// Include in any module that needs the scan geometry or DRP constants
// ----------------------------------------
`ifndef EYESCAN_DEFINES_SVH
`define EYESCAN_DEFINES_SVH

// Scan grid
`define ES_H_STEPS 8 // Columns per row
`define ES_V_STEPS 4 // Rows
`define ES_H_START 4
`define ES_H_STEP  1
`define ES_V_START 3
`define ES_V_STEP  2

// DRP register addresses
`define ES_ADDR_VERT   9'h03B
`define ES_ADDR_HORZ   9'h03C
`define ES_ADDR_CTRL   9'h03D
`define ES_ADDR_ERRCNT 9'h14F
`define ES_ADDR_SMPCNT 9'h150
`define ES_ADDR_STATUS 9'h151

// ES_CONTROL commands and status codes
`define ES_CMD_RUN        16'hE301
`define ES_CMD_STOP       16'hE300
`define ES_STATUS_RUNNING 16'd6 // Whole status word
`define ES_STATUS_DONE    3'd2  // Status bits 3..1

`endif

//--- files.f
+incdir+.
eyeScanPkg.sv
drpMaster.sv
sweepSequencer.sv
pixelStore.sv
eyeScan.sv
gtxDrpModel.sv
tbEyeScan.sv

//--- gtxDrpModel.sv
// ----------------------------------------
// Behavioral transceiver DRP responder for the testbench
// Random ready latency, eye scan status and counter registers
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "eyeScan_defines.svh"

module gtxDrpModel
    import eyeScanPkg::*;
(
    input  wire logic    CLK,
    input  wire logic    rstN,
    input  wire drpAddrT drpAddr,
    input  wire drpDataT drpDi,
    input  wire logic    drpEn,
    input  wire logic    drpWe,
    output drpDataT      drpDo,
    output logic         drpRdy,
    output int           enableCount,  // Every drpEn seen
    output int           overlapCount  // drpEn while still busy
);

    drpDataT vertReg;
    drpDataT horzReg;
    drpAddrT pendAddr;
    logic    pendWrite;
    logic    busy;
    int      waitCycles;
    int      runPolls;   // Status reads left that report running
    logic    rdyNext;
    drpDataT doNext;

    // Quiet DRP response before the first clock edge
    initial begin
        drpRdy = 1'b0;
        drpDo  = '0;
    end

    always @(posedge CLK) begin
        rdyNext = 1'b0;
        doNext  = '0;
        if (!rstN) begin
            busy         = 1'b0;
            waitCycles   = 0;
            runPolls     = 0;
            vertReg      = '0;
            horzReg      = '0;
            pendAddr     = '0;
            pendWrite    = 1'b0;
            enableCount  = 0;
            overlapCount = 0;
        end else begin
            if (busy && drpEn) begin
                overlapCount++;
                $display("DRP model at %0t ns: enable arrived while a transaction is outstanding",
                         $time);
            end
            if (busy) begin
                waitCycles--;
                if (waitCycles == 0) begin
                    busy    = 1'b0;
                    rdyNext = 1'b1;
                    if (!pendWrite) begin
                        case (pendAddr)
                            `ES_ADDR_STATUS: begin
                                if (runPolls > 0) begin
                                    runPolls--;
                                    doNext = `ES_STATUS_RUNNING;
                                end else begin
                                    doNext = {12'h000, `ES_STATUS_DONE, 1'b0};
                                end
                            end
                            `ES_ADDR_SMPCNT: doNext = 16'h4000 + {8'h00, horzReg[7:0]};
                            `ES_ADDR_ERRCNT: doNext = {8'h00, vertReg[7:0] ^ horzReg[7:0]};
                            default:         doNext = '0;
                        endcase
                    end
                end
            end
            if (drpEn) begin
                enableCount++;
                if (!busy) begin
                    busy       = 1'b1;
                    waitCycles = $urandom_range(8, 1);
                    pendAddr   = drpAddr;
                    pendWrite  = drpWe;
                    if (drpWe) begin
                        case (drpAddr)
                            `ES_ADDR_VERT: vertReg = drpDi;
                            `ES_ADDR_HORZ: horzReg = drpDi;
                            `ES_ADDR_CTRL: if (drpDi == `ES_CMD_RUN) runPolls = $urandom_range(3, 1);
                            default: ;
                        endcase
                    end
                end
            end
        end
        #2; // Outputs change shortly after the edge
        drpRdy = rdyNext;
        drpDo  = doNext;
    end

endmodule

`default_nettype wire

//--- pixelStore.sv
// ----------------------------------------
// Result memory, one record per pixel
// Written by the sequencer, read back with one cycle latency
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pixelStore
    import eyeScanPkg::*;
(
    input  wire logic      CLK,
    input  wire logic      pixWe,
    input  wire pixelAddrT pixAddr,
    input  wire drpDataT   pixVert,
    input  wire drpDataT   pixHorz,
    input  wire countT     pixSamples,
    input  wire countT     pixErrors,
    input  wire pixelAddrT rdAddr,
    output drpDataT        rdVert,
    output drpDataT        rdHorz,
    output countT          rdSamples,
    output countT          rdErrors
);

    localparam int Depth = 2 ** $bits(pixelAddrT);

    // Record layout is vert, horz, samples, errors from the top
    logic [63:0] mem [Depth];
    logic [63:0] rdRecord;

    always_ff @(posedge CLK) begin
        if (pixWe) begin
            mem[pixAddr] <= {pixVert, pixHorz, pixSamples, pixErrors};
        end
        rdRecord <= mem[rdAddr]; // Registered read
    end

    assign rdVert    = rdRecord[63:48];
    assign rdHorz    = rdRecord[47:32];
    assign rdSamples = rdRecord[31:16];
    assign rdErrors  = rdRecord[15:0];

endmodule

`default_nettype wire

//--- sweepSequencer.sv
// ----------------------------------------
// Eye scan sweep FSM
// Walks the grid row by row, runs the DRP sequence for each pixel
// and hands the finished record to the pixel store
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "eyeScan_defines.svh"

module sweepSequencer
    import eyeScanPkg::*;
(
    input  wire logic     CLK,
    input  wire logic     rstN,
    input  wire logic     runScan,
    input  wire prescaleT prescale,
    input  wire logic     opDone,
    input  wire drpDataT  rdData,
    output logic          reqStrobe,
    output logic          reqWrite,
    output drpAddrT       reqAddr,
    output drpDataT       reqData,
    output logic          pixWe,
    output pixelAddrT     pixAddr,
    output drpDataT       pixVert,
    output drpDataT       pixHorz,
    output countT         pixSamples,
    output countT         pixErrors,
    output logic          scanComplete
);

    seqStateT state;
    rowT      row;
    colT      col;
    prescaleT prescaleReg;
    countT    samples;
    countT    errors;
    logic     runPrev;
    logic     runRise;
    logic     runFall;
    logic     issued;  // Request sent from the current step
    logic     pending; // Master still busy, also across an abort
    logic     statusDone;
    logic [7:0]  vOff;
    logic [7:0]  vMag;
    logic [10:0] hOff;

    assign runRise = runScan && !runPrev;
    assign runFall = !runScan && runPrev;

    // Offset words for the current pixel
    assign vOff = 8'(`ES_V_START) - 8'(row) * 8'(`ES_V_STEP);
    assign vMag = vOff[7] ? (~vOff + 8'd1) : vOff;
    assign hOff = 11'(`ES_H_START) - 11'(col) * 11'(`ES_H_STEP);

    assign pixVert = {prescaleReg, 2'b00, 1'b0, vOff[7], vMag[6:0]}; // UT bit fixed at 0
    assign pixHorz = {4'b0000, hOff[10], hOff};
    assign pixAddr = 5'(row) * 5'(`ES_H_STEPS) + 5'(col);
    assign pixSamples = samples;
    assign pixErrors  = errors;
    assign pixWe      = (state == seqStore);

    assign statusDone = (rdData[3:1] == `ES_STATUS_DONE) || (rdData[3:1] == 3'd0);

    assign reqStrobe = (state != seqIdle) && (state != seqStore)
                    && !issued && !pending && !runFall;

    // Request fields per step, polls read the status register
    always_comb begin
        reqWrite = 1'b0;
        reqAddr  = `ES_ADDR_STATUS;
        reqData  = '0;
        case (state)
            seqVert: begin
                reqWrite = 1'b1;
                reqAddr  = `ES_ADDR_VERT;
                reqData  = pixVert;
            end
            seqHorz: begin
                reqWrite = 1'b1;
                reqAddr  = `ES_ADDR_HORZ;
                reqData  = pixHorz;
            end
            seqRun: begin
                reqWrite = 1'b1;
                reqAddr  = `ES_ADDR_CTRL;
                reqData  = `ES_CMD_RUN;
            end
            seqStop: begin
                reqWrite = 1'b1;
                reqAddr  = `ES_ADDR_CTRL;
                reqData  = `ES_CMD_STOP;
            end
            seqSamples: reqAddr = `ES_ADDR_SMPCNT;
            seqErrors:  reqAddr = `ES_ADDR_ERRCNT;
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            state        <= seqIdle;
            row          <= '0;
            col          <= '0;
            runPrev      <= 1'b0;
            issued       <= 1'b0;
            pending      <= 1'b0;
            scanComplete <= 1'b0;
        end else begin
            runPrev <= runScan;
            if (reqStrobe) begin
                pending <= 1'b1;
            end else if (opDone) begin
                pending <= 1'b0;
            end
            if (runFall) begin
                state  <= seqIdle; // Abort, any open transaction drains in the master
                issued <= 1'b0;
            end else begin
                case (state)
                    seqIdle: begin
                        if (runRise) begin
                            scanComplete <= 1'b0;
                            row          <= '0;
                            col          <= '0;
                            state        <= seqVert;
                        end
                    end
                    seqStore: begin
                        state <= seqVert;
                        if (col == colT'(`ES_H_STEPS - 1)) begin
                            col <= '0;
                            if (row == rowT'(`ES_V_STEPS - 1)) begin
                                scanComplete <= 1'b1;
                                state        <= seqIdle;
                            end else begin
                                row <= row + 1'b1;
                            end
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                    default: begin
                        if (reqStrobe) begin
                            issued <= 1'b1;
                        end else if (issued && opDone) begin
                            issued <= 1'b0; // Clearing alone repeats a poll
                            case (state)
                                seqVert:     state <= seqHorz;
                                seqHorz:     state <= seqRun;
                                seqRun:      state <= seqPollRun;
                                seqPollRun:  if (rdData == `ES_STATUS_RUNNING) state <= seqPollDone;
                                seqPollDone: if (statusDone) state <= seqStop;
                                seqStop:     state <= seqSamples;
                                seqSamples:  state <= seqErrors;
                                seqErrors:   state <= seqStore;
                                default:     state <= seqIdle;
                            endcase
                        end
                    end
                endcase
            end
        end
    end

    // Scan prescale and counter readback
    always_ff @(posedge CLK) begin
        if (state == seqIdle && runRise) begin
            prescaleReg <= prescale;
        end
        if (issued && opDone && state == seqSamples) begin
            samples <= rdData;
        end
        if (issued && opDone && state == seqErrors) begin
            errors <= rdData;
        end
    end

endmodule

`default_nettype wire

//--- tbEyeScan.sv
// ----------------------------------------
// Testbench for the eye scan controller
// Full scans, prescale change, abort mid-scan, then readout checks
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "eyeScan_defines.svh"

module tbEyeScan
    import eyeScanPkg::*;
();

    localparam int NumPixels      = `ES_H_STEPS * `ES_V_STEPS;
    localparam int ScanCycleLimit = 8000; // Worst case is about 4000 cycles

    logic      CLK;
    logic      rstN;
    logic      runScan;
    prescaleT  prescale;
    logic      scanComplete;
    drpAddrT   drpAddr;
    drpDataT   drpDi;
    logic      drpEn;
    logic      drpWe;
    drpDataT   drpDo;
    logic      drpRdy;
    pixelAddrT rdAddr;
    drpDataT   rdVert;
    drpDataT   rdHorz;
    countT     rdSamples;
    countT     rdErrors;
    int        enableCount;
    int        overlapCount;
    int        errors = 0;
    int        compareReqs = 0;
    int        comparesDone = 0;
    prescaleT  expPrescale;

    eyeScan u_eyeScan (
        .CLK, .rstN, .runScan, .prescale, .scanComplete,
        .drpAddr, .drpDi, .drpEn, .drpWe, .drpDo, .drpRdy,
        .rdAddr, .rdVert, .rdHorz, .rdSamples, .rdErrors
    );

    gtxDrpModel u_gtxDrpModel (
        .CLK, .rstN, .drpAddr, .drpDi, .drpEn, .drpWe, .drpDo, .drpRdy,
        .enableCount, .overlapCount
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // Expected record {vert, horz, samples, errors} for one pixel
    function automatic logic [63:0] expectedRecord(int index, prescaleT ps);
        int         row;
        int         col;
        int         vOff;
        int         hOff;
        logic [6:0] vMag;
        drpDataT    vert;
        drpDataT    horz;
        countT      samples;
        countT      errs;
        row     = index / `ES_H_STEPS;
        col     = index % `ES_H_STEPS;
        vOff    = `ES_V_START - row * `ES_V_STEP;
        hOff    = `ES_H_START - col * `ES_H_STEP;
        vMag    = 7'((vOff < 0) ? -vOff : vOff);
        vert    = {ps, 2'b00, 1'b0, (vOff < 0), vMag}; // UT bit 0
        horz    = {4'b0000, (hOff < 0), 11'(hOff)};
        samples = 16'h4000 + {8'h00, horz[7:0]};
        errs    = {8'h00, vert[7:0] ^ horz[7:0]};
        return {vert, horz, samples, errs};
    endfunction

    task automatic checkField(string name, logic [15:0] expected, logic [15:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic waitScanComplete();
        int cycles;
        cycles = 0;
        while (scanComplete !== 1'b1 && cycles < ScanCycleLimit) begin
            @(posedge CLK);
            #2;
            cycles++;
        end
        if (scanComplete !== 1'b1) begin
            errors++;
            $display("Scan did not complete within %0d cycles", ScanCycleLimit);
        end
    endtask

    // Hand the readout to the compare process and wait for it
    task automatic compareAllPixels();
        compareReqs++;
        wait (comparesDone == compareReqs);
    endtask

    task automatic runFullScan(prescaleT ps);
        prescale    = ps;
        expPrescale = ps;
        runScan     = 1'b1;
        repeat (2) @(posedge CLK);
        #2;
        checkField("scanComplete after start", 16'h0000, {15'h0000, scanComplete});
        waitScanComplete();
        if (scanComplete === 1'b1) begin
            compareAllPixels();
        end
        runScan = 1'b0;
        @(posedge CLK);
        #2;
    endtask

    task automatic abortScan(prescaleT ps);
        int startCount;
        int dropCount;
        int drainCount;
        int cycles;
        int highCycles;
        prescale   = ps;
        runScan    = 1'b1;
        startCount = enableCount;
        cycles     = 0;
        while (enableCount < startCount + 100 && cycles < ScanCycleLimit) begin
            @(posedge CLK);
            #2;
            cycles++;
        end
        if (enableCount < startCount + 100) begin
            errors++;
            $display("Scan made no DRP progress before the abort");
        end
        checkField("scanComplete mid-scan", 16'h0000, {15'h0000, scanComplete});
        runScan   = 1'b0;
        dropCount = enableCount;
        repeat (2) @(posedge CLK);
        #2;
        drainCount = enableCount;
        if (drainCount - dropCount > 1) begin
            errors++;
            $display("More than one DRP enable followed the abort");
        end
        highCycles = 0;
        repeat (500) begin
            @(posedge CLK);
            #2;
            if (scanComplete !== 1'b0) highCycles++;
        end
        if (highCycles != 0) begin
            errors++;
            $display("scanComplete went high after the abort for %0d cycles", highCycles);
        end
        if (enableCount != drainCount) begin
            errors++;
            $display("DRP enables kept coming after the abort, %0d extra",
                     enableCount - drainCount);
        end
    endtask

    // Readout and compare of all pixels, one pass per request
    initial begin
        logic [63:0] exp;
        rdAddr = '0;
        forever begin
            wait (compareReqs > comparesDone);
            for (int i = 0; i < NumPixels; i++) begin
                @(posedge CLK);
                #2;
                rdAddr = pixelAddrT'(i);
                @(posedge CLK);
                #2;
                exp = expectedRecord(i, expPrescale);
                checkField($sformatf("rdVert[%0d]", i), exp[63:48], rdVert);
                checkField($sformatf("rdHorz[%0d]", i), exp[47:32], rdHorz);
                checkField($sformatf("rdSamples[%0d]", i), exp[31:16], rdSamples);
                checkField($sformatf("rdErrors[%0d]", i), exp[15:0], rdErrors);
            end
            comparesDone++;
        end
    end

    initial begin
        void'($urandom(32'h0b3e6116));
        rstN        = 1'b0;
        runScan     = 1'b0;
        prescale    = '0;
        expPrescale = '0;
        repeat (16) @(posedge CLK);
        #2;
        rstN = 1'b1;

        // Quiet bus before any start
        repeat (20) begin
            @(posedge CLK);
            #2;
            checkField("drpEn before start", 16'h0000, {15'h0000, drpEn});
            checkField("drpWe before start", 16'h0000, {15'h0000, drpWe});
            checkField("scanComplete before start", 16'h0000, {15'h0000, scanComplete});
        end

        runFullScan(5'd0);
        checkField("scanComplete before second scan", 16'h0001, {15'h0000, scanComplete});
        runFullScan(5'd21);
        abortScan(5'd13);
        runFullScan(5'd9);

        if (overlapCount != 0) begin
            errors += overlapCount;
            $display("DRP model saw %0d enables during an open transaction", overlapCount);
        end
        $display("Eye scan test finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog, about three worst-case scans plus margin
    initial begin
        #2_000_000;
        $display("Watchdog expired at %0t ns before the test sequence finished", $time);
        $display("Eye scan test finished with %0d errors", errors);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
